// File: rtl/keypad_pkg.sv
`default_nettype none

package keypad_pkg;

    // codes as the scanner reports them. 12 to 15 never occur.
    typedef enum logic [3:0] {
        KEY_0     = 4'd0,
        KEY_1     = 4'd1,
        KEY_2     = 4'd2,
        KEY_3     = 4'd3,
        KEY_4     = 4'd4,
        KEY_5     = 4'd5,
        KEY_6     = 4'd6,
        KEY_7     = 4'd7,
        KEY_8     = 4'd8,
        KEY_9     = 4'd9,
        KEY_ENTER = 4'd10,
        KEY_CLEAR = 4'd11
    } key_code_e;

    localparam int ROWS = 4;                        // keypad rows, driven one-cold.
    localparam logic [ROWS-1:0] ROW_IDLE = 4'b1110; // first row pattern after reset.

    // scan tick every 2**SCAN_DIV_BITS clocks, small for simulation.
    localparam int SCAN_DIV_BITS = 4;

endpackage

`default_nettype wire

// File: rtl/calc_pkg.sv
`default_nettype none

package calc_pkg;

    localparam int OPERAND_W   = 4;
    localparam int PRODUCT_W   = 2 * OPERAND_W;
    localparam int OPERAND_MAX = (1 << OPERAND_W) - 1; // 15.

    typedef enum logic [1:0] {
        ENTER_A,
        ENTER_B,
        SHOW
    } calc_state_e;

endpackage

`default_nettype wire

// File: rtl/keypad_scanner.sv
`timescale 1ns/100ps
`default_nettype none

module keypad_scanner (
    input  wire                              CLOCK_50,
    input  wire                              arst_n,
    input  wire  [3:0]                       cols,
    output logic [keypad_pkg::ROWS-1:0]      rows,
    output logic                             key_valid,
    output keypad_pkg::key_code_e            key_code
);

    logic [keypad_pkg::SCAN_DIV_BITS-1:0] div_cnt;
    logic                                 tick;
    logic [3:0]                           cols_meta;
    logic [3:0]                           cols_sync;
    logic                                 hit;
    keypad_pkg::key_code_e                code;
    logic                                 pressed;
    logic [$clog2(keypad_pkg::ROWS)-1:0]  miss_cnt;
    logic                                 new_press;

    // free running divider, tick on the last count.
    always_ff @(posedge CLOCK_50 or negedge arst_n) begin
        if (!arst_n) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    assign tick = &div_cnt;

    // columns come straight from the pads.
    always_ff @(posedge CLOCK_50 or negedge arst_n) begin
        if (!arst_n) begin
            cols_meta <= '1;
            cols_sync <= '1;
        end else begin
            cols_meta <= cols;
            cols_sync <= cols_meta;
        end
    end

    always_ff @(posedge CLOCK_50 or negedge arst_n) begin
        if (!arst_n) begin
            rows <= keypad_pkg::ROW_IDLE;
        end else if (tick) begin
            rows <= {rows[keypad_pkg::ROWS-2:0], rows[keypad_pkg::ROWS-1]}; // rotate the zero.
        end
    end

    // column 3 is not wired to a key on any row.
    always_comb begin
        hit  = 1'b1;
        code = keypad_pkg::KEY_0;
        case ({rows, cols_sync})
            8'b1110_1110: code = keypad_pkg::KEY_1;
            8'b1110_1101: code = keypad_pkg::KEY_2;
            8'b1110_1011: code = keypad_pkg::KEY_3;
            8'b1101_1110: code = keypad_pkg::KEY_4;
            8'b1101_1101: code = keypad_pkg::KEY_5;
            8'b1101_1011: code = keypad_pkg::KEY_6;
            8'b1011_1110: code = keypad_pkg::KEY_7;
            8'b1011_1101: code = keypad_pkg::KEY_8;
            8'b1011_1011: code = keypad_pkg::KEY_9;
            8'b0111_1110: code = keypad_pkg::KEY_ENTER;
            8'b0111_1101: code = keypad_pkg::KEY_0;
            8'b0111_1011: code = keypad_pkg::KEY_CLEAR;
            default:      hit  = 1'b0;
        endcase
    end

    assign new_press = tick && hit && !pressed;

    // a held key is seen once per scan, so a full scan of misses means release.
    always_ff @(posedge CLOCK_50 or negedge arst_n) begin
        if (!arst_n) begin
            pressed   <= 1'b0;
            miss_cnt  <= '0;
            key_valid <= 1'b0;
        end else begin
            key_valid <= new_press;
            if (tick) begin
                if (hit) begin
                    pressed  <= 1'b1;
                    miss_cnt <= '0;
                end else if (pressed) begin
                    if (int'(miss_cnt) == keypad_pkg::ROWS - 1) begin
                        pressed  <= 1'b0;
                        miss_cnt <= '0;
                    end else begin
                        miss_cnt <= miss_cnt + 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (new_press) begin
            key_code <= code; // lands together with key_valid.
        end
    end

endmodule

`default_nettype wire

// File: rtl/entry_controller.sv
`timescale 1ns/100ps
`default_nettype none

module entry_controller (
    input  wire                                 CLOCK_50,
    input  wire                                 arst_n,
    input  wire                                 key_valid,
    input  wire keypad_pkg::key_code_e          key_code,
    output logic [calc_pkg::OPERAND_W-1:0]      operand_a,
    output logic [calc_pkg::OPERAND_W-1:0]      operand_b,
    input  wire  [calc_pkg::PRODUCT_W-1:0]      product,
    output logic [calc_pkg::PRODUCT_W-1:0]      led
);

    calc_pkg::calc_state_e                  state;
    logic                                   is_digit;
    logic [calc_pkg::OPERAND_W-1:0]         digit;
    logic [calc_pkg::OPERAND_W-1:0]         cur_operand;
    logic [calc_pkg::PRODUCT_W-1:0]         cur_wide;
    logic [calc_pkg::PRODUCT_W-1:0]         accum;
    logic [calc_pkg::OPERAND_W-1:0]         next_operand;

    assign is_digit    = (key_code <= keypad_pkg::KEY_9);
    assign digit       = key_code;
    assign cur_operand = (state == calc_pkg::ENTER_B) ? operand_b : operand_a;

    // ten times the operand plus the new digit, 159 at most.
    assign cur_wide = {{(calc_pkg::PRODUCT_W - calc_pkg::OPERAND_W){1'b0}}, cur_operand};
    assign accum    = (cur_wide << 3) + (cur_wide << 1)
                    + {{(calc_pkg::PRODUCT_W - calc_pkg::OPERAND_W){1'b0}}, digit};

    // too large, so the digit starts a new number.
    assign next_operand = (int'(accum) <= calc_pkg::OPERAND_MAX) ?
                          accum[calc_pkg::OPERAND_W-1:0] : digit;

    always_ff @(posedge CLOCK_50 or negedge arst_n) begin
        if (!arst_n) begin
            state     <= calc_pkg::ENTER_A;
            operand_a <= '0;
            operand_b <= '0;
        end else if (key_valid) begin
            if (key_code == keypad_pkg::KEY_CLEAR) begin
                state     <= calc_pkg::ENTER_A;
                operand_a <= '0;
                operand_b <= '0;
            end else begin
                case (state)
                    calc_pkg::ENTER_A: begin
                        if (is_digit) begin
                            operand_a <= next_operand;
                        end else if (key_code == keypad_pkg::KEY_ENTER) begin
                            state <= calc_pkg::ENTER_B;
                        end
                    end
                    calc_pkg::ENTER_B: begin
                        if (is_digit) begin
                            operand_b <= next_operand;
                        end else if (key_code == keypad_pkg::KEY_ENTER) begin
                            state <= calc_pkg::SHOW;
                        end
                    end
                    calc_pkg::SHOW: begin
                        state <= calc_pkg::SHOW; // waits for clear.
                    end
                    default: begin
                        state <= calc_pkg::ENTER_A;
                    end
                endcase
            end
        end
    end

    // operands side by side while typing, then the product.
    always_comb begin
        if (state == calc_pkg::SHOW) begin
            led = product;
        end else begin
            led = {operand_a, operand_b};
        end
    end

endmodule

`default_nettype wire

// File: rtl/array_multiplier.sv
`timescale 1ns/100ps
`default_nettype none

module array_multiplier (
    input  wire [calc_pkg::OPERAND_W-1:0]   a,
    input  wire [calc_pkg::OPERAND_W-1:0]   b,
    output wire [calc_pkg::PRODUCT_W-1:0]   product
);

    wire [calc_pkg::OPERAND_W-1:0] pp    [calc_pkg::OPERAND_W];
    wire [calc_pkg::OPERAND_W-1:0] upper [calc_pkg::OPERAND_W];   // carried into the next row.
    wire [calc_pkg::OPERAND_W-1:0] sum   [1:calc_pkg::OPERAND_W-1];
    wire [calc_pkg::OPERAND_W:0]   carry [1:calc_pkg::OPERAND_W-1];

    genvar r, i;

    for (r = 0; r < calc_pkg::OPERAND_W; r++) begin : g_pp
        assign pp[r] = a & {calc_pkg::OPERAND_W{b[r]}};
    end

    // row 0 needs no adder, its low bit is final.
    assign product[0] = pp[0][0];
    assign upper[0]   = {1'b0, pp[0][calc_pkg::OPERAND_W-1:1]};

    for (r = 1; r < calc_pkg::OPERAND_W; r++) begin : g_row
        assign carry[r][0] = 1'b0;
        for (i = 0; i < calc_pkg::OPERAND_W; i++) begin : g_fa
            assign sum[r][i]     = upper[r-1][i] ^ pp[r][i] ^ carry[r][i];
            assign carry[r][i+1] = (upper[r-1][i] & pp[r][i])
                                 | (upper[r-1][i] & carry[r][i])
                                 | (pp[r][i] & carry[r][i]);
        end
        assign product[r] = sum[r][0];
        assign upper[r]   = {carry[r][calc_pkg::OPERAND_W], sum[r][calc_pkg::OPERAND_W-1:1]};
    end

    // last row gives the high half.
    assign product[calc_pkg::PRODUCT_W-1:calc_pkg::OPERAND_W] = upper[calc_pkg::OPERAND_W-1];

endmodule

`default_nettype wire

// File: rtl/keypad_calc_top.sv
`timescale 1ns/100ps
`default_nettype none

module keypad_calc_top (
    input  wire                             CLOCK_50,
    input  wire                             arst_n,
    input  wire  [3:0]                      cols,
    output logic [keypad_pkg::ROWS-1:0]     rows,
    output logic [calc_pkg::PRODUCT_W-1:0]  led
);

    logic                           key_valid;
    keypad_pkg::key_code_e          key_code;
    logic [calc_pkg::OPERAND_W-1:0] operand_a;
    logic [calc_pkg::OPERAND_W-1:0] operand_b;
    logic [calc_pkg::PRODUCT_W-1:0] product;

    keypad_scanner i_keypad_scanner (
        .CLOCK_50  (CLOCK_50),
        .arst_n    (arst_n),
        .cols      (cols),
        .rows      (rows),
        .key_valid (key_valid),
        .key_code  (key_code)
    );

    entry_controller i_entry_controller (
        .CLOCK_50  (CLOCK_50),
        .arst_n    (arst_n),
        .key_valid (key_valid),
        .key_code  (key_code),
        .operand_a (operand_a),
        .operand_b (operand_b),
        .product   (product),
        .led       (led)
    );

    array_multiplier i_array_multiplier (
        .a       (operand_a),
        .b       (operand_b),
        .product (product)
    );

endmodule

`default_nettype wire

// File: tb/tb_keypad_calc.sv
`timescale 1ns/100ps
`default_nettype none

module tb_keypad_calc;

    localparam int TICK_CLOCKS  = 1 << keypad_pkg::SCAN_DIV_BITS;
    localparam int TICK_TIMEOUT = 2 * TICK_CLOCKS;   // one tick period with margin.
    localparam int PRESS_SCANS  = 3;                 // 3*ROWS ticks down and as many up.
    localparam int NO_KEY       = -1;
    localparam int RESET_CODE   = 15;
    localparam int RANDOM_PAIRS = 20;

    logic                           CLOCK_50;
    logic                           arst_n;
    logic [3:0]                     cols = 4'hf;
    logic [keypad_pkg::ROWS-1:0]    rows;
    logic [calc_pkg::PRODUCT_W-1:0] led;

    int                             held_key  = NO_KEY;
    int                             errors    = 0;
    int                             timeouts  = 0;
    logic [keypad_pkg::ROWS-1:0]    rows_seen = '0;

    keypad_calc_top i_keypad_calc_top (
        .CLOCK_50 (CLOCK_50),
        .arst_n   (arst_n),
        .cols     (cols),
        .rows     (rows),
        .led      (led)
    );

    initial begin
        CLOCK_50 = 1'b0;
        forever #5 CLOCK_50 = ~CLOCK_50;
    end

    // rows hold 1 2 3 / 4 5 6 / 7 8 9 / enter 0 clear and column 3 stays open.
    function automatic logic [3:0] key_cols(input int key, input logic [3:0] row_drive);
        int row_idx;
        int col_idx;
        row_idx = -1;
        col_idx = 0;
        if (key >= 1 && key <= 9) begin
            row_idx = (key - 1) / 3;
            col_idx = (key - 1) % 3;
        end else if (key == int'(keypad_pkg::KEY_ENTER)) begin
            row_idx = 3;
            col_idx = 0;
        end else if (key == int'(keypad_pkg::KEY_0)) begin
            row_idx = 3;
            col_idx = 1;
        end else if (key == int'(keypad_pkg::KEY_CLEAR)) begin
            row_idx = 3;
            col_idx = 2;
        end
        if (row_idx < 0 || row_drive[row_idx] !== 1'b0) begin
            return 4'hf;
        end
        return ~(4'b0001 << col_idx);
    endfunction

    // keypad switches close onto the driven row.
    always @(negedge CLOCK_50) begin
        cols <= key_cols(held_key, rows);
    end

    function automatic logic [7:0] entry_led(input int a_val, input int partial, input bit into_b);
        if (into_b) begin
            return 8'(a_val * 16 + partial);
        end
        return 8'(partial * 16);
    endfunction

    task automatic check_led(input int key, input logic [7:0] expected);
        assert (led === expected) else begin
            $display("Mismatch at %0t: after key %0d led expected %02h, got %02h",
                     $time, key, expected, led);
            errors++;
        end
    endtask

    // one tick is seen as the row drive moving on.
    task automatic wait_ticks(input int n);
        logic [keypad_pkg::ROWS-1:0] last;
        int                          clocks;
        int                          t;
        for (t = 0; t < n; t++) begin
            last   = rows;
            clocks = 0;
            while (rows === last && clocks < TICK_TIMEOUT) begin
                @(negedge CLOCK_50);
                clocks++;
            end
            assert (rows !== last) else begin
                $display("timeout: row drive did not advance within %0d clocks at time %0t",
                         TICK_TIMEOUT, $time);
                timeouts++;
            end
            assert ($countones(~rows) == 1) else begin
                $display("Mismatch at %0t: row drive %b is not one-cold", $time, rows);
                errors++;
            end
            rows_seen = rows_seen | ~rows;
        end
    endtask

    task automatic press_key(input int key, input int scans, input logic [7:0] expected);
        held_key <= key;
        wait_ticks(scans * keypad_pkg::ROWS);
        held_key <= NO_KEY;
        wait_ticks(PRESS_SCANS * keypad_pkg::ROWS);
        check_led(key, expected);
    endtask

    task automatic pulse_reset();
        held_key <= NO_KEY;
        arst_n = 1'b0;
        repeat (4) @(negedge CLOCK_50);
        arst_n = 1'b1;
        assert (rows === keypad_pkg::ROW_IDLE) else begin
            $display("Mismatch at %0t: rows after reset expected %b, got %b",
                     $time, keypad_pkg::ROW_IDLE, rows);
            errors++;
        end
    endtask

    // starts from a zero operand, so at most two digits are needed.
    task automatic type_operand(input int value, input int a_val, input bit into_b);
        if (value >= 10) begin
            press_key(1, PRESS_SCANS, entry_led(a_val, 1, into_b));
            press_key(value - 10, PRESS_SCANS, entry_led(a_val, value, into_b));
        end else begin
            press_key(value, PRESS_SCANS, entry_led(a_val, value, into_b));
        end
    endtask

    task automatic run_case_file();
        int    fd;
        int    key;
        int    expected;
        int    cases;
        string line;
        cases = 0;
        fd    = $fopen("tb/calc_cases.txt", "r");
        assert (fd != 0) else begin
            $display("could not open the case file tb/calc_cases.txt");
            errors++;
        end
        if (fd == 0) begin
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if ($sscanf(line, "%d %h", key, expected) == 2) begin   // comment lines fail here.
                cases++;
                if (key == RESET_CODE) begin
                    pulse_reset();
                    check_led(key, 8'(expected));
                end else begin
                    press_key(key, PRESS_SCANS, 8'(expected));
                end
            end
        end
        $fclose(fd);
        assert (cases > 0) else begin
            $display("the case file held no usable lines");
            errors++;
        end
    endtask

    task automatic run_random_pairs();
        int a_val;
        int b_val;
        int i;
        for (i = 0; i < RANDOM_PAIRS; i++) begin
            a_val = $urandom % 16;
            b_val = $urandom % 16;
            press_key(int'(keypad_pkg::KEY_CLEAR), PRESS_SCANS, 8'h00);
            type_operand(a_val, 0, 1'b0);
            press_key(int'(keypad_pkg::KEY_ENTER), PRESS_SCANS, entry_led(0, a_val, 1'b0));
            type_operand(b_val, a_val, 1'b1);
            press_key(int'(keypad_pkg::KEY_ENTER), PRESS_SCANS, 8'(a_val * b_val));
        end
    endtask

    initial begin
        arst_n = 1'b0;
        void'($urandom(40103));
        pulse_reset();
        check_led(RESET_CODE, 8'h00);
        run_case_file();

        // a second strobe from the long hold would turn A into 11.
        press_key(int'(keypad_pkg::KEY_CLEAR), PRESS_SCANS, 8'h00);
        press_key(1, 10, 8'h10);
        press_key(2, PRESS_SCANS, 8'hc0);

        run_random_pairs();

        assert (rows_seen == '1) else begin
            $display("not every keypad row was driven during the run, seen %b", rows_seen);
            errors++;
        end

        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/calc_cases.txt
# key code in decimal (10 enter, 11 clear, 15 reset pulse),
# then the led value expected after it, in hex.
15 00
1 10
2 c0
3 30
10 30
4 34
5 35
10 0f
7 0f
11 00
1 10
5 f0
10 f0
1 f1
5 ff
10 e1
11 00
1 10
10 10
8 18
11 00
6 60
10 60
9 69
0 60
10 00
15 00

// File: project.f
rtl/keypad_pkg.sv
rtl/calc_pkg.sv
rtl/keypad_scanner.sv
rtl/entry_controller.sv
rtl/array_multiplier.sv
rtl/keypad_calc_top.sv
tb/tb_keypad_calc.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the keypad calculator testbench with Verilator and runs it.
set -u

cd "$(dirname "$0")" || exit 1

TOP=tb_keypad_calc
BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module "$TOP" --Mdir "$BUILD_DIR" -o "$TOP" \
    -f project.f
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

"./$BUILD_DIR/$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "FAIL: see errors above" "$LOG"; then
    echo "simulation reported a failure, see $LOG"
    exit 1
fi

echo "simulation finished without failures"
exit 0
